/* tb/arp_rx_patterns.txt */
# F tuser nbytes byte... outcome (0 dropped, 1 request, 2 learned, 3 short, 4 bad lengths)
# L ip expected_hit expected_mac
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 01 08 06 00 01 08 00 06 04 00 01 02 11 22 33 44 01 0a 00 00 01 00 00 00 00 00 00 c0 a8 00 01 1
L 0a000001 1 021122334401
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 63 08 00 00 01 08 00 06 04 00 01 02 11 22 33 44 63 0a 00 00 63 00 00 00 00 00 00 c0 a8 00 01 0
L 0a000063 0 000000000000
F 0 34 ff ff ff ff ff ff 02 00 00 00 00 64 08 06 00 01 08 00 06 04 00 01 02 11 22 33 44 64 0a 00 00 64 00 00 3
L 0a000064 0 000000000000
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 65 08 06 00 01 08 00 05 04 00 01 02 11 22 33 44 65 0a 00 00 65 00 00 00 00 00 00 c0 a8 00 01 4
L 0a000065 0 000000000000
F 1 42 ff ff ff ff ff ff 02 00 00 00 00 66 08 06 00 01 08 00 06 04 00 01 02 11 22 33 44 66 0a 00 00 66 00 00 00 00 00 00 c0 a8 00 01 0
L 0a000066 0 000000000000
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 02 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 02 0a 00 00 02 00 00 00 00 00 00 c0 a8 00 01 2
L 0a000002 1 021122334402
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 03 08 06 00 01 08 00 06 04 00 01 02 11 22 33 44 03 0a 00 00 03 00 00 00 00 00 00 c0 a8 00 63 2
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 04 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 04 0a 00 00 04 00 00 00 00 00 00 c0 a8 00 01 2
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 05 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 05 0a 00 00 05 00 00 00 00 00 00 c0 a8 00 01 2
F 0 46 ff ff ff ff ff ff 02 00 00 00 00 06 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 06 0a 00 00 06 00 00 00 00 00 00 c0 a8 00 01 00 00 00 00 2
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 07 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 07 0a 00 00 07 00 00 00 00 00 00 c0 a8 00 01 2
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 08 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 08 0a 00 00 08 00 00 00 00 00 00 c0 a8 00 01 2
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 09 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 09 0a 00 00 09 00 00 00 00 00 00 c0 a8 00 01 2
L 0a000001 0 000000000000
L 0a000009 1 021122334409
L 0a000003 1 021122334403
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 05 08 06 00 01 08 00 06 04 00 01 02 aa bb cc dd 05 0a 00 00 05 00 00 00 00 00 00 c0 a8 00 01 1
L 0a000005 1 02aabbccdd05
F 0 42 ff ff ff ff ff ff 02 00 00 00 00 0a 08 06 00 01 08 00 06 04 00 02 02 11 22 33 44 0a 0a 00 00 0a 00 00 00 00 00 00 c0 a8 00 01 2
L 0a000002 0 000000000000
L 0a000004 1 021122334404
L 0a00000a 1 02112233440a

/* vlog.f */
rtl/arp_pkg.sv
rtl/eth_frame_rx.sv
rtl/arp_frame_rx.sv
rtl/arp_cache.sv
rtl/arp_rx_top.sv
tb/arp_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the ARP receive testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module arp_rx_tb \
    -o arp_rx_sim \
    && ./obj_dir/arp_rx_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb/arp_rx_tb.sv */
// ARP receive path testbench reading frames, lookups and expected results from a pattern file
module arp_rx_tb
    import arp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam ip_addr_t LOCAL_IP    = 32'hc0a8_0001;
    localparam int       MARGIN      = 4;
    localparam int       KIND_FRAME  = 0;
    localparam int       KIND_LOOKUP = 1;

    logic      clk = 1'b0;
    logic      rst;
    byte_t     s_tdata;
    logic      s_tvalid;
    logic      s_tready;
    logic      s_tlast;
    logic      s_tuser;
    ip_addr_t  local_ip;
    logic      lookup_valid;
    logic      lookup_ready;
    ip_addr_t  lookup_ip;
    logic      lookup_resp_valid;
    logic      lookup_hit;
    mac_addr_t lookup_mac;
    logic      req_valid;
    mac_addr_t req_sha;
    ip_addr_t  req_spa;
    logic      busy;
    logic      error_header_early_termination;
    logic      error_invalid_header;

    // one entry per record with frame and lookup fields side by side
    byte_t     frame_bytes[$];
    int        rec_kind[$];
    int        rec_tuser[$];
    int        rec_len[$];
    int        rec_start[$];
    int        rec_outcome[$];
    ip_addr_t  rec_ip[$];
    logic      rec_hit[$];
    mac_addr_t rec_mac[$];

    int        req_count = 0;
    int        early_count = 0;
    int        invalid_count = 0;
    mac_addr_t last_req_sha;
    ip_addr_t  last_req_spa;
    int        test_errors = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    int        limit_cycles = 0;

    always #2 clk = ~clk;

    arp_rx_top uut (
        .clk                            (clk),
        .rst                            (rst),
        .s_tdata                        (s_tdata),
        .s_tvalid                       (s_tvalid),
        .s_tready                       (s_tready),
        .s_tlast                        (s_tlast),
        .s_tuser                        (s_tuser),
        .local_ip                       (local_ip),
        .lookup_valid                   (lookup_valid),
        .lookup_ready                   (lookup_ready),
        .lookup_ip                      (lookup_ip),
        .lookup_resp_valid              (lookup_resp_valid),
        .lookup_hit                     (lookup_hit),
        .lookup_mac                     (lookup_mac),
        .req_valid                      (req_valid),
        .req_sha                        (req_sha),
        .req_spa                        (req_spa),
        .busy                           (busy),
        .error_header_early_termination (error_header_early_termination),
        .error_invalid_header           (error_invalid_header)
    );

    // count pulses for the frame tests to read one edge later
    always @(posedge clk) begin
        if (req_valid) begin
            req_count    <= req_count + 1;
            last_req_sha <= req_sha;
            last_req_spa <= req_spa;
        end
        if (error_header_early_termination) begin
            early_count <= early_count + 1;
        end
        if (error_invalid_header) begin
            invalid_count <= invalid_count + 1;
        end
    end

    // watchdog armed once the pattern file is loaded
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("** Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic load_patterns(output logic ok);
        int fd;
        int c;
        int rc;
        int tu;
        int len;
        int oc;
        logic [31:0] v;
        mac_addr_t m;
        fd = $fopen("tb/arp_rx_patterns.txt", "r");
        ok = fd != 0;
        if (ok) begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == int'("#")) begin
                    while (c != int'("\n") && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (c == int'("F")) begin
                    rc = $fscanf(fd, "%d %d", tu, len);
                    if (rc != 2) begin
                        ok = 1'b0;
                    end
                    rec_kind.push_back(KIND_FRAME);
                    rec_tuser.push_back(tu);
                    rec_len.push_back(len);
                    rec_start.push_back(frame_bytes.size());
                    for (int i = 0; i < len; i++) begin
                        rc = $fscanf(fd, "%h", v);
                        if (rc != 1) begin
                            ok = 1'b0;
                        end
                        frame_bytes.push_back(v[7:0]);
                    end
                    rc = $fscanf(fd, "%d", oc);
                    if (rc != 1) begin
                        ok = 1'b0;
                    end
                    rec_outcome.push_back(oc);
                    rec_ip.push_back('0);
                    rec_hit.push_back(1'b0);
                    rec_mac.push_back('0);
                end else if (c == int'("L")) begin
                    rc = $fscanf(fd, "%h %d %h", v, tu, m);
                    if (rc != 3) begin
                        ok = 1'b0;
                    end
                    rec_kind.push_back(KIND_LOOKUP);
                    rec_tuser.push_back(0);
                    rec_len.push_back(0);
                    rec_start.push_back(0);
                    rec_outcome.push_back(0);
                    rec_ip.push_back(v);
                    rec_hit.push_back(tu != 0);
                    rec_mac.push_back(m);
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic send_frame(input int start, input int len, input int tu);
        for (int i = 0; i < len; i++) begin
            // random idle cycle before some bytes
            if (($urandom & 32'd3) == 32'd0) begin
                s_tvalid <= 1'b0;
                @(posedge clk);
            end
            s_tdata  <= frame_bytes[start + i];
            s_tvalid <= 1'b1;
            s_tlast  <= i == len - 1;
            s_tuser  <= i == len - 1 && tu != 0;
            @(posedge clk);
            while (!s_tready) @(posedge clk);
        end
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        s_tuser  <= 1'b0;
    endtask

    // wait for an idle decoder and no pending learn write plus one edge for the counters
    task automatic wait_settled();
        @(posedge clk);
        while (busy || !lookup_ready) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic run_frame_test(input int r);
        int start;
        int req0;
        int early0;
        int inv0;
        int exp_req;
        int exp_early;
        int exp_inv;
        mac_addr_t exp_sha;
        ip_addr_t exp_spa;
        start     = rec_start[r];
        req0      = req_count;
        early0    = early_count;
        inv0      = invalid_count;
        exp_req   = rec_outcome[r] == 1 ? 1 : 0;
        exp_early = rec_outcome[r] == 3 ? 1 : 0;
        exp_inv   = rec_outcome[r] == 4 ? 1 : 0;
        send_frame(start, rec_len[r], rec_tuser[r]);
        wait_settled();
        if (req_count - req0 != exp_req) begin
            report_mismatch("req_valid pulses", 64'(exp_req), 64'(req_count - req0));
        end
        if (early_count - early0 != exp_early) begin
            report_mismatch("error_header_early_termination pulses", 64'(exp_early),
                            64'(early_count - early0));
        end
        if (invalid_count - inv0 != exp_inv) begin
            report_mismatch("error_invalid_header pulses", 64'(exp_inv),
                            64'(invalid_count - inv0));
        end
        if (exp_req == 1) begin
            // sender hw and protocol address sit behind oper in the ARP header
            exp_sha = '0;
            exp_spa = '0;
            for (int j = 0; j < 6; j++) begin
                exp_sha = {exp_sha[39:0], frame_bytes[start + ETH_HDR_BYTES + 8 + j]};
            end
            for (int j = 0; j < 4; j++) begin
                exp_spa = {exp_spa[23:0], frame_bytes[start + ETH_HDR_BYTES + 14 + j]};
            end
            if (last_req_sha !== exp_sha) begin
                report_mismatch("req_sha", 64'(exp_sha), 64'(last_req_sha));
            end
            if (last_req_spa !== exp_spa) begin
                report_mismatch("req_spa", 64'(exp_spa), 64'(last_req_spa));
            end
        end
        $display("test %0d: frame of %0d bytes, outcome %0d, %s", r + 1, rec_len[r],
                 rec_outcome[r], test_errors == 0 ? "ok" : "FAILED");
    endtask

    task automatic run_lookup_test(input int r);
        lookup_ip    <= rec_ip[r];
        lookup_valid <= 1'b1;
        @(posedge clk);
        while (!lookup_ready) @(posedge clk);
        lookup_valid <= 1'b0;
        if (lookup_resp_valid !== 1'b0) begin
            report_mismatch("lookup_resp_valid at accept", 64'(0), 64'(lookup_resp_valid));
        end
        // result due exactly one edge after acceptance
        @(posedge clk);
        if (lookup_resp_valid !== 1'b1) begin
            report_mismatch("lookup_resp_valid", 64'(1), 64'(lookup_resp_valid));
        end
        if (lookup_hit !== rec_hit[r]) begin
            report_mismatch("lookup_hit", 64'(rec_hit[r]), 64'(lookup_hit));
        end
        if (lookup_mac !== rec_mac[r]) begin
            report_mismatch("lookup_mac", 64'(rec_mac[r]), 64'(lookup_mac));
        end
        @(posedge clk);
        if (lookup_resp_valid !== 1'b0) begin
            report_mismatch("lookup_resp_valid after pulse", 64'(0), 64'(lookup_resp_valid));
        end
        $display("test %0d: lookup %h, expected hit %0d, %s", r + 1, rec_ip[r], rec_hit[r],
                 test_errors == 0 ? "ok" : "FAILED");
    endtask

    initial begin
        logic load_ok;
        $timeformat(-9, 0, " ns", 0);
        rst          = 1'b1;
        s_tdata      = '0;
        s_tvalid     = 1'b0;
        s_tlast      = 1'b0;
        s_tuser      = 1'b0;
        local_ip     = LOCAL_IP;
        lookup_valid = 1'b0;
        lookup_ip    = '0;
        void'($urandom(32'he5c9_1691));
        load_patterns(load_ok);
        if (!load_ok) begin
            $display("could not read tb/arp_rx_patterns.txt");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            // two cycles per byte cover the gaps and each record adds a fixed share
            limit_cycles = MARGIN * (2 * frame_bytes.size() + 16 * rec_kind.size() + 32);
            repeat (16) @(posedge clk);
            rst <= 1'b0;
            @(posedge clk);
            for (int r = 0; r < rec_kind.size(); r++) begin
                test_errors = 0;
                if (rec_kind[r] == KIND_FRAME) begin
                    run_frame_test(r);
                end else begin
                    run_lookup_test(r);
                end
                if (test_errors == 0) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
            end
            $display("%0d tests, %0d passed, %0d failed", rec_kind.size(), pass_count,
                     fail_count);
            if (fail_count == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

/* rtl/arp_rx_top.sv */
// ARP receive path top level, splitter into decoder into cache
module arp_rx_top
    import arp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  byte_t     s_tdata,
    input  logic      s_tvalid,
    output logic      s_tready,
    input  logic      s_tlast,
    input  logic      s_tuser,

    input  ip_addr_t  local_ip,

    input  logic      lookup_valid,
    output logic      lookup_ready,
    input  ip_addr_t  lookup_ip,
    output logic      lookup_resp_valid,
    output logic      lookup_hit,
    output mac_addr_t lookup_mac,

    output logic      req_valid,
    output mac_addr_t req_sha,
    output ip_addr_t  req_spa,

    output logic      busy,
    output logic      error_header_early_termination,
    output logic      error_invalid_header
);

    // splitter to decoder
    logic        hdr_valid;
    logic        hdr_ready;
    mac_addr_t   hdr_src_mac;
    byte_t       pl_tdata;
    logic        pl_tvalid;
    logic        pl_tready;
    logic        pl_tlast;
    logic        pl_tuser;

    // decoder to cache
    logic        frame_valid;
    logic        frame_ready;
    mac_addr_t   frame_src_mac;
    logic [15:0] arp_htype;
    logic [15:0] arp_ptype;
    logic [15:0] arp_oper;
    mac_addr_t   arp_sha;
    ip_addr_t    arp_spa;
    ip_addr_t    arp_tpa;

    // dest MAC and ethertype are already settled by the splitter
    eth_frame_rx u_eth_rx (
        .clk                (clk),
        .rst                (rst),
        .s_tdata            (s_tdata),
        .s_tvalid           (s_tvalid),
        .s_tready           (s_tready),
        .s_tlast            (s_tlast),
        .s_tuser            (s_tuser),
        .eth_hdr_valid      (hdr_valid),
        .eth_hdr_ready      (hdr_ready),
        .eth_dest_mac       (),
        .eth_src_mac        (hdr_src_mac),
        .eth_type           (),
        .eth_payload_tdata  (pl_tdata),
        .eth_payload_tvalid (pl_tvalid),
        .eth_payload_tready (pl_tready),
        .eth_payload_tlast  (pl_tlast),
        .eth_payload_tuser  (pl_tuser)
    );

    arp_frame_rx u_arp_rx (
        .clk                            (clk),
        .rst                            (rst),
        .eth_hdr_valid                  (hdr_valid),
        .eth_hdr_ready                  (hdr_ready),
        .hdr_src_mac                    (hdr_src_mac),
        .eth_payload_tdata              (pl_tdata),
        .eth_payload_tvalid             (pl_tvalid),
        .eth_payload_tready             (pl_tready),
        .eth_payload_tlast              (pl_tlast),
        .eth_payload_tuser              (pl_tuser),
        .frame_valid                    (frame_valid),
        .frame_ready                    (frame_ready),
        .eth_src_mac                    (frame_src_mac),
        .arp_htype                      (arp_htype),
        .arp_ptype                      (arp_ptype),
        .arp_oper                       (arp_oper),
        .arp_sha                        (arp_sha),
        .arp_spa                        (arp_spa),
        .arp_tpa                        (arp_tpa),
        .busy                           (busy),
        .error_header_early_termination (error_header_early_termination),
        .error_invalid_header           (error_invalid_header)
    );

    arp_cache u_cache (
        .clk               (clk),
        .rst               (rst),
        .frame_valid       (frame_valid),
        .frame_ready       (frame_ready),
        .eth_src_mac       (frame_src_mac),
        .arp_htype         (arp_htype),
        .arp_ptype         (arp_ptype),
        .arp_oper          (arp_oper),
        .arp_sha           (arp_sha),
        .arp_spa           (arp_spa),
        .arp_tpa           (arp_tpa),
        .local_ip          (local_ip),
        .req_valid         (req_valid),
        .req_sha           (req_sha),
        .req_spa           (req_spa),
        .lookup_valid      (lookup_valid),
        .lookup_ready      (lookup_ready),
        .lookup_ip         (lookup_ip),
        .lookup_resp_valid (lookup_resp_valid),
        .lookup_hit        (lookup_hit),
        .lookup_mac        (lookup_mac)
    );

endmodule

/* rtl/arp_cache.sv */
// ARP cache with learn port, local request detection and IP lookup
module arp_cache
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        frame_valid,
    output logic        frame_ready,
    input  mac_addr_t   eth_src_mac,
    input  logic [15:0] arp_htype,
    input  logic [15:0] arp_ptype,
    input  logic [15:0] arp_oper,
    input  mac_addr_t   arp_sha,
    input  ip_addr_t    arp_spa,
    input  ip_addr_t    arp_tpa,

    input  ip_addr_t    local_ip,
    output logic        req_valid,
    output mac_addr_t   req_sha,
    output ip_addr_t    req_spa,

    input  logic        lookup_valid,
    output logic        lookup_ready,
    input  ip_addr_t    lookup_ip,
    output logic        lookup_resp_valid,
    output logic        lookup_hit,
    output mac_addr_t   lookup_mac
);

    logic [CACHE_ENTRIES-1:0] tbl_valid;
    ip_addr_t  tbl_ip  [CACHE_ENTRIES];
    mac_addr_t tbl_mac [CACHE_ENTRIES];

    logic run;
    logic pending;
    logic learn_ok;
    logic learn_req;
    ip_addr_t learn_ip;
    mac_addr_t learn_mac;
    logic [CACHE_IDX_W-1:0] rr_ptr;
    logic [CACHE_IDX_W-1:0] match_idx;
    logic [CACHE_IDX_W-1:0] wr_idx;
    logic match_any;
    ip_addr_t cmp_ip;
    logic frame_take;
    logic lookup_take;

    // a pending learn owns the table for one cycle
    assign frame_ready  = run && !pending;
    assign lookup_ready = run && !pending;
    assign frame_take   = frame_valid && frame_ready;
    assign lookup_take  = lookup_valid && lookup_ready;

    assign req_sha = learn_mac;
    assign req_spa = learn_ip;

    // one comparator bank shared by learn and lookup
    assign cmp_ip = pending ? learn_ip : lookup_ip;
    assign wr_idx = match_any ? match_idx : rr_ptr;

    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        for (int i = 0; i < CACHE_ENTRIES; i++) begin
            if (tbl_valid[i] && tbl_ip[i] == cmp_ip) begin
                match_any = 1'b1;
                match_idx = CACHE_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run               <= 1'b0;
            pending           <= 1'b0;
            req_valid         <= 1'b0;
            lookup_resp_valid <= 1'b0;
            lookup_hit        <= 1'b0;
            tbl_valid         <= '0;
            rr_ptr            <= '0;
        end else begin
            run               <= 1'b1;
            pending           <= frame_take;
            req_valid         <= pending && learn_req;
            lookup_resp_valid <= lookup_take;
            if (lookup_take) begin
                lookup_hit <= match_any;
            end
            if (pending && learn_ok) begin
                tbl_valid[wr_idx] <= 1'b1;
                // known IPs update in place and keep the pointer
                if (!match_any) begin
                    rr_ptr <= rr_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_take) begin
            learn_ip  <= arp_spa;
            // zero sender hw address, fall back to the frame source
            learn_mac <= (arp_sha == '0) ? eth_src_mac : arp_sha;
            learn_ok  <= arp_htype == ARP_HTYPE_ETH && arp_ptype == ARP_PTYPE_IPV4;
            learn_req <= arp_oper == ARP_OPER_REQUEST && arp_tpa == local_ip;
        end
        if (pending && learn_ok) begin
            tbl_ip[wr_idx]  <= learn_ip;
            tbl_mac[wr_idx] <= learn_mac;
        end
        if (lookup_take) begin
            lookup_mac <= match_any ? tbl_mac[match_idx] : '0;
        end
    end

endmodule

/* rtl/arp_frame_rx.sv */
// ARP header decoder, parallel field output with length and truncation checks
module arp_frame_rx
    import arp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        eth_hdr_valid,
    output logic        eth_hdr_ready,
    input  mac_addr_t   hdr_src_mac,
    input  byte_t       eth_payload_tdata,
    input  logic        eth_payload_tvalid,
    output logic        eth_payload_tready,
    input  logic        eth_payload_tlast,
    input  logic        eth_payload_tuser,

    output logic        frame_valid,
    input  logic        frame_ready,
    output mac_addr_t   eth_src_mac,
    output logic [15:0] arp_htype,
    output logic [15:0] arp_ptype,
    output logic [15:0] arp_oper,
    output mac_addr_t   arp_sha,
    output ip_addr_t    arp_spa,
    output ip_addr_t    arp_tpa,

    output logic        busy,
    output logic        error_header_early_termination,
    output logic        error_invalid_header
);

    localparam logic [4:0] LAST_PTR = 5'(ARP_HDR_BYTES - 1);

    arp_rx_state_t state;
    logic [4:0] ptr;
    byte_t hlen;
    byte_t plen;
    logic run;
    logic hdr_take;
    logic byte_take;
    logic frame_end;
    logic short_frame;
    logic lens_ok;

    // no new header while a decoded frame waits for the cache
    assign eth_hdr_ready      = run && state == ARP_IDLE && !frame_valid;
    assign eth_payload_tready = state != ARP_IDLE;

    assign hdr_take    = eth_hdr_valid && eth_hdr_ready;
    assign byte_take   = eth_payload_tvalid && eth_payload_tready;
    assign frame_end   = byte_take && eth_payload_tlast;
    assign short_frame = state == ARP_READ_HEADER && ptr != LAST_PTR;
    assign lens_ok     = hlen == ARP_HLEN && plen == ARP_PLEN;

    assign busy = state != ARP_IDLE || frame_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state                          <= ARP_IDLE;
            ptr                            <= '0;
            run                            <= 1'b0;
            frame_valid                    <= 1'b0;
            error_header_early_termination <= 1'b0;
            error_invalid_header           <= 1'b0;
        end else begin
            run                            <= 1'b1;
            error_header_early_termination <= 1'b0;
            error_invalid_header           <= 1'b0;
            if (frame_ready) begin
                frame_valid <= 1'b0;
            end

            case (state)
                ARP_IDLE: begin
                    ptr <= '0;
                    if (hdr_take) begin
                        state <= ARP_READ_HEADER;
                    end
                end
                ARP_READ_HEADER: begin
                    if (byte_take) begin
                        ptr <= ptr + 5'd1;
                        if (ptr == LAST_PTR) begin
                            state <= ARP_WAIT_LAST;
                        end
                    end
                end
                default: ;
            endcase

            // end of frame overrides the normal step
            if (frame_end) begin
                state <= ARP_IDLE;
                // bad frames from the MAC vanish without an error
                if (!eth_payload_tuser) begin
                    if (short_frame) begin
                        error_header_early_termination <= 1'b1;
                    end else if (!lens_ok) begin
                        error_invalid_header <= 1'b1;
                    end else begin
                        frame_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // big-endian fields, each byte shifts into the low end of its field
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            eth_src_mac <= hdr_src_mac;
        end
        if (byte_take && state == ARP_READ_HEADER) begin
            case (ptr) inside
                [5'd0:5'd1]:   arp_htype <= {arp_htype[7:0], eth_payload_tdata};
                [5'd2:5'd3]:   arp_ptype <= {arp_ptype[7:0], eth_payload_tdata};
                5'd4:          hlen <= eth_payload_tdata;
                5'd5:          plen <= eth_payload_tdata;
                [5'd6:5'd7]:   arp_oper <= {arp_oper[7:0], eth_payload_tdata};
                [5'd8:5'd13]:  arp_sha <= {arp_sha[39:0], eth_payload_tdata};
                [5'd14:5'd17]: arp_spa <= {arp_spa[23:0], eth_payload_tdata};
                // target hw address is not kept
                [5'd24:5'd27]: arp_tpa <= {arp_tpa[23:0], eth_payload_tdata};
                default: ;
            endcase
        end
    end

endmodule

/* rtl/eth_frame_rx.sv */
// Ethernet header splitter that forwards ARP frames and drops all others
module eth_frame_rx
    import arp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  byte_t      s_tdata,
    input  logic       s_tvalid,
    output logic       s_tready,
    input  logic       s_tlast,
    input  logic       s_tuser,

    output logic       eth_hdr_valid,
    input  logic       eth_hdr_ready,
    output mac_addr_t  eth_dest_mac,
    output mac_addr_t  eth_src_mac,
    output ethertype_t eth_type,

    output byte_t      eth_payload_tdata,
    output logic       eth_payload_tvalid,
    input  logic       eth_payload_tready,
    output logic       eth_payload_tlast,
    output logic       eth_payload_tuser
);

    eth_rx_state_t state;
    logic [3:0] hdr_cnt;
    logic [8*ETH_HDR_BYTES-1:0] hdr_shift;
    logic run;
    logic hdr_byte;
    logic hdr_last;

    // header bytes shift in from the low end, so dest MAC ends up on top
    assign eth_dest_mac = hdr_shift[111:64];
    assign eth_src_mac  = hdr_shift[63:16];
    assign eth_type     = hdr_shift[15:0];

    assign eth_hdr_valid = state == ETH_HEADER;

    // payload passes straight through once the header is taken
    assign eth_payload_tdata  = s_tdata;
    assign eth_payload_tvalid = s_tvalid && state == ETH_PAYLOAD;
    assign eth_payload_tlast  = s_tlast;
    assign eth_payload_tuser  = s_tuser;

    always_comb begin
        case (state)
            ETH_IDLE:    s_tready = run;
            ETH_PAYLOAD: s_tready = eth_payload_tready;
            ETH_DROP:    s_tready = 1'b1;
            default:     s_tready = 1'b0;
        endcase
    end

    assign hdr_byte = state == ETH_IDLE && run && s_tvalid;
    assign hdr_last = hdr_cnt == 4'(ETH_HDR_BYTES - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ETH_IDLE;
            hdr_cnt <= '0;
            run     <= 1'b0;
        end else begin
            run <= 1'b1;
            case (state)
                ETH_IDLE: begin
                    if (hdr_byte) begin
                        if (s_tlast) begin
                            // frame ended inside the header
                            hdr_cnt <= '0;
                        end else if (hdr_last) begin
                            hdr_cnt <= '0;
                            if ({hdr_shift[7:0], s_tdata} == ETHERTYPE_ARP) begin
                                state <= ETH_HEADER;
                            end else begin
                                state <= ETH_DROP;
                            end
                        end else begin
                            hdr_cnt <= hdr_cnt + 4'd1;
                        end
                    end
                end
                ETH_HEADER: begin
                    if (eth_hdr_ready) begin
                        state <= ETH_PAYLOAD;
                    end
                end
                ETH_PAYLOAD: begin
                    if (s_tvalid && eth_payload_tready && s_tlast) begin
                        state <= ETH_IDLE;
                    end
                end
                ETH_DROP: begin
                    if (s_tvalid && s_tlast) begin
                        state <= ETH_IDLE;
                    end
                end
                default: state <= ETH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_byte) begin
            hdr_shift <= {hdr_shift[8*ETH_HDR_BYTES-9:0], s_tdata};
        end
    end

endmodule

/* rtl/arp_pkg.sv */
// shared widths, ethertype and ARP constants, cache sizing, FSM state types
package arp_pkg;

    // field widths that carry a meaning on the wire
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [7:0]  byte_t;

    localparam ethertype_t ETHERTYPE_ARP = 16'h0806;

    // fixed ARP header values for IPv4 over Ethernet
    localparam logic [15:0] ARP_HTYPE_ETH    = 16'd1;
    localparam logic [15:0] ARP_PTYPE_IPV4   = 16'h0800;
    localparam byte_t       ARP_HLEN         = 8'd6;
    localparam byte_t       ARP_PLEN         = 8'd4;
    localparam logic [15:0] ARP_OPER_REQUEST = 16'd1;

    localparam int ETH_HDR_BYTES = 14;
    localparam int ARP_HDR_BYTES = 28;

    // cache size, index width must cover the entry count
    localparam int CACHE_ENTRIES = 8;
    localparam int CACHE_IDX_W   = 3;

    // idle collects header bytes, header holds them for the decoder
    typedef enum logic [1:0] {
        ETH_IDLE,
        ETH_HEADER,
        ETH_PAYLOAD,
        ETH_DROP
    } eth_rx_state_t;

    typedef enum logic [1:0] {
        ARP_IDLE,
        ARP_READ_HEADER,
        ARP_WAIT_LAST
    } arp_rx_state_t;

endpackage
